// File: verilog/mem_check_pkg.sv
package mem_check_pkg;

    localparam int ADDR_W        = 10;
    localparam int DATA_W        = 36;
    localparam int RAM_DEPTH     = 1024;
    localparam int LAST_ADDR     = 1023;
    localparam int PATTERN_SHIFT = 16;

    typedef logic [ADDR_W-1:0] ram_addr_t;
    typedef logic [DATA_W-1:0] ram_word_t;
    typedef logic [15:0]       err_count_t;

    // Read request from the sequencer
    typedef struct packed {
        ram_addr_t addr;
        logic      valid;
        logic      last;
    } scan_req_t;

    typedef struct packed {
        logic       valid;
        logic       mismatch;
        logic       pass_done;
        ram_addr_t  addr;
        ram_word_t  expected;
        ram_word_t  actual;
        err_count_t err_count;
    } cmp_result_t;

    // Address in the low field, copy of it at PATTERN_SHIFT, rest zero
    function automatic ram_word_t pattern_word(ram_addr_t a);
        ram_word_t w;
        w = '0;
        w[ADDR_W-1:0] = a;
        w[PATTERN_SHIFT +: ADDR_W] = a;
        return w;
    endfunction

endpackage

// File: verilog/report_pkg.sv
package report_pkg;

    typedef logic [7:0] byte_t;

    localparam byte_t TAG_ERROR = 8'hEE;
    localparam byte_t TAG_PASS  = 8'hC0;

    // Error frame: tag, addr(2), expected(5), actual(5)
    localparam int ERR_FRAME_LEN  = 13;
    // Pass frame: tag, count(2)
    localparam int PASS_FRAME_LEN = 3;
    localparam int FRAME_BUF_LEN  = ERR_FRAME_LEN + PASS_FRAME_LEN;

    localparam int BAUD_DIV        = 8;
    localparam int UART_FRAME_BITS = 10;
    localparam int BAUD_CNT_W      = $clog2(BAUD_DIV);
    localparam int BIT_CNT_W       = $clog2(UART_FRAME_BITS);

    typedef logic [ERR_FRAME_LEN*8-1:0]  err_frame_t;
    typedef logic [PASS_FRAME_LEN*8-1:0] pass_frame_t;
    typedef logic [FRAME_BUF_LEN*8-1:0]  frame_buf_t;
    typedef logic [$clog2(FRAME_BUF_LEN)-1:0] byte_idx_t;

    typedef enum logic [1:0] {
        REP_IDLE,
        REP_LOAD,
        REP_SEND,
        REP_WAIT_TX
    } rep_state_t;

endpackage

// File: verilog/scan_sequencer.sv
module scan_sequencer
    import mem_check_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      stall,
    output scan_req_t req
);

    // Address to issue on the next unstalled cycle
    ram_addr_t next_addr;
    logic      next_is_last;

    assign next_is_last = (next_addr == ram_addr_t'(LAST_ADDR));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            next_addr <= '0;
            req       <= '0;
        end else if (!stall) begin
            req.addr  <= next_addr;
            req.valid <= 1'b1;
            req.last  <= next_is_last;
            // Counter overflow takes LAST_ADDR back to 0
            next_addr <= next_addr + 1'b1;
        end
    end

endmodule

// File: verilog/pattern_ram.sv
module pattern_ram
    import mem_check_pkg::*;
(
    input  logic      clk,
    input  scan_req_t req,
    input  logic      stall,
    input  logic      wr_en,
    input  ram_addr_t wr_addr,
    input  ram_word_t wr_data,
    output ram_word_t rd_data
);

    ram_word_t mem [RAM_DEPTH];

    // Power-up contents follow the pattern rule
    initial begin
        for (int i = 0; i < RAM_DEPTH; i++) begin
            mem[i] = pattern_word(ram_addr_t'(i));
        end
    end

    // Read before write on a shared address
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        if (req.valid && !stall) begin
            rd_data <= mem[req.addr];
        end
    end

endmodule

// File: verilog/read_compare.sv
module read_compare
    import mem_check_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  scan_req_t   req,
    input  ram_word_t   rd_data,
    output cmp_result_t result
);

    // Request delayed to line up with rd_data
    scan_req_t  req_d;
    ram_word_t  expected;
    logic       mismatch;
    logic       pass_end;
    err_count_t err_cnt;
    err_count_t cnt_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_d <= '0;
        end else if (!stall) begin
            req_d <= req;
        end
    end

    always_comb begin
        expected = pattern_word(req_d.addr);
        mismatch = req_d.valid && (rd_data != expected);
        pass_end = req_d.valid && req_d.last;
        cnt_next = err_cnt + err_count_t'(mismatch);
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            result.addr      <= req_d.addr;
            result.expected  <= expected;
            result.actual    <= rd_data;
            result.err_count <= cnt_next;
        end
        if (!rst_n) begin
            result.valid     <= 1'b0;
            result.mismatch  <= 1'b0;
            result.pass_done <= 1'b0;
            err_cnt          <= '0;
        end else if (!stall) begin
            result.valid     <= req_d.valid;
            result.mismatch  <= mismatch;
            result.pass_done <= pass_end;
            // New pass starts counting from zero
            if (pass_end) begin
                err_cnt <= '0;
            end else begin
                err_cnt <= cnt_next;
            end
        end
    end

endmodule

// File: verilog/error_reporter.sv
module error_reporter
    import mem_check_pkg::*;
    import report_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  cmp_result_t result,
    input  logic        tx_busy,
    output byte_t       tx_byte,
    output logic        tx_start,
    output logic        report_busy,
    output logic        pass_pulse
);

    rep_state_t  state;
    cmp_result_t hold_q;
    frame_buf_t  frame_q;
    byte_idx_t   byte_idx;
    byte_idx_t   last_idx;
    err_frame_t  err_frame;
    pass_frame_t pass_frame;
    logic        take;

    assign take        = (state == REP_IDLE) && result.valid &&
                         (result.mismatch || result.pass_done);
    assign report_busy = (state != REP_IDLE);

    // Words are zero-extended to 40 bits, address to 16
    always_comb begin
        err_frame  = {TAG_ERROR,
                      {(16 - ADDR_W){1'b0}}, hold_q.addr,
                      {(40 - DATA_W){1'b0}}, hold_q.expected,
                      {(40 - DATA_W){1'b0}}, hold_q.actual};
        pass_frame = {TAG_PASS, hold_q.err_count};
    end

    always_ff @(posedge clk) begin
        if (take) begin
            hold_q <= result;
        end
        if (!rst_n) begin
            state      <= REP_IDLE;
            tx_start   <= 1'b0;
            pass_pulse <= 1'b0;
            byte_idx   <= '0;
            last_idx   <= '0;
        end else begin
            tx_start   <= 1'b0;
            pass_pulse <= take && result.pass_done;
            case (state)
                REP_IDLE: begin
                    if (take) begin
                        state <= REP_LOAD;
                    end
                end
                REP_LOAD: begin
                    // Error frame goes first when both are due
                    if (hold_q.mismatch && hold_q.pass_done) begin
                        frame_q  <= {err_frame, pass_frame};
                        last_idx <= byte_idx_t'(FRAME_BUF_LEN - 1);
                    end else if (hold_q.mismatch) begin
                        frame_q  <= {err_frame, {(PASS_FRAME_LEN * 8){1'b0}}};
                        last_idx <= byte_idx_t'(ERR_FRAME_LEN - 1);
                    end else begin
                        frame_q  <= {pass_frame, {(ERR_FRAME_LEN * 8){1'b0}}};
                        last_idx <= byte_idx_t'(PASS_FRAME_LEN - 1);
                    end
                    byte_idx <= '0;
                    state    <= REP_SEND;
                end
                REP_SEND: begin
                    tx_byte  <= frame_q[FRAME_BUF_LEN*8-1 -: 8];
                    tx_start <= 1'b1;
                    state    <= REP_WAIT_TX;
                end
                REP_WAIT_TX: begin
                    // tx_busy is still low in the cycle the strobe is up
                    if (!tx_start && !tx_busy) begin
                        if (byte_idx == last_idx) begin
                            state <= REP_IDLE;
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                            frame_q  <= frame_q << 8;
                            state    <= REP_SEND;
                        end
                    end
                end
                default: state <= REP_IDLE;
            endcase
        end
    end

endmodule

// File: verilog/uart_tx.sv
module uart_tx
    import report_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  byte_t tx_byte,
    input  logic  tx_start,
    output logic  tx,
    output logic  tx_busy
);

    // Stop, data LSB first, start; bit 0 drives the line
    logic [UART_FRAME_BITS-1:0] shift_q;
    logic [BAUD_CNT_W-1:0]      baud_cnt;
    logic [BIT_CNT_W-1:0]       bit_cnt;

    // Ones shift in behind the stop bit, so the line idles high
    assign tx = shift_q[0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shift_q  <= '1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            tx_busy  <= 1'b0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                shift_q  <= {1'b1, tx_byte, 1'b0};
                baud_cnt <= '0;
                bit_cnt  <= '0;
                tx_busy  <= 1'b1;
            end
        end else if (baud_cnt == BAUD_CNT_W'(BAUD_DIV - 1)) begin
            baud_cnt <= '0;
            shift_q  <= {1'b1, shift_q[UART_FRAME_BITS-1:1]};
            if (bit_cnt == BIT_CNT_W'(UART_FRAME_BITS - 1)) begin
                tx_busy <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

endmodule

// File: verilog/bram_check_top.sv
module bram_check_top
    import mem_check_pkg::*;
    import report_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      wr_en,
    input  ram_addr_t wr_addr,
    input  ram_word_t wr_data,
    output logic      tx,
    output logic      pass_pulse
);

    scan_req_t   req;
    ram_word_t   rd_data;
    cmp_result_t result;
    byte_t       tx_byte;
    logic        tx_start;
    logic        tx_busy;
    // Reporter busy level freezes the whole read pipeline
    logic        stall;

    scan_sequencer seq_i (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (stall),
        .req   (req)
    );

    pattern_ram ram_i (
        .clk     (clk),
        .req     (req),
        .stall   (stall),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_data (rd_data)
    );

    read_compare cmp_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .stall   (stall),
        .req     (req),
        .rd_data (rd_data),
        .result  (result)
    );

    error_reporter rep_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .result      (result),
        .tx_busy     (tx_busy),
        .tx_byte     (tx_byte),
        .tx_start    (tx_start),
        .report_busy (stall),
        .pass_pulse  (pass_pulse)
    );

    uart_tx uart_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_byte  (tx_byte),
        .tx_start (tx_start),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

endmodule

// File: verif/bram_check_sva.sv
module bram_check_sva
    import mem_check_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input logic        tx,
    input logic        pass_pulse,
    input logic        stall,
    input logic        tx_start,
    input scan_req_t   req,
    input cmp_result_t result
);

    // Set by the first byte strobe after reset
    logic frame_seen;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            frame_seen <= 1'b0;
        end else if (tx_start) begin
            frame_seen <= 1'b1;
        end
    end

    idle_line_high: assert property (@(posedge clk) disable iff (!rst_n)
        !stall |-> tx)
        else $error("tx low while the reporter is idle");

    single_pass_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        pass_pulse |=> !pass_pulse)
        else $error("pass_pulse high on two consecutive cycles");

    stall_vs_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(pass_pulse) |-> !$rose(stall))
        else $error("stall rose in the cycle pass_pulse fell");

    // Sequencer moves on every unstalled cycle
    advance_unstalled: assert property (@(posedge clk) disable iff (!rst_n)
        !stall |=> (req != $past(req)))
        else $error("read request held without stall");

    hold_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> ($stable(req) && $stable(result)))
        else $error("pipeline moved while stalled");

    quiet_until_first_frame: assert property (@(posedge clk) disable iff (!rst_n)
        !frame_seen |-> tx)
        else $error("tx left idle before the first frame");

endmodule

bind bram_check_top bram_check_sva sva_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .tx         (tx),
    .pass_pulse (pass_pulse),
    .stall      (stall),
    .tx_start   (tx_start),
    .req        (req),
    .result     (result)
);

// File: verif/bram_check_tb.sv
module bram_check_tb
    import mem_check_pkg::*;
    import report_pkg::*;
();

    localparam int          CLK_PERIOD      = 20;
    localparam logic [31:0] LFSR_SEED       = 32'h875bb8b9;
    localparam int          N_INJECT        = 4;
    localparam int          WATCHDOG_CYCLES = 8 * 1100 + 1100 * N_INJECT;
    localparam int          FRAME_WAIT      = 3000;

    typedef struct packed {
        byte_t       tag;
        logic [15:0] addr;
        logic [39:0] expected;
        logic [39:0] actual;
        err_count_t  count;
    } frame_rec_t;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      wr_en;
    ram_addr_t wr_addr;
    ram_word_t wr_data;
    logic      tx;
    logic      pass_pulse;

    frame_rec_t  frames[$];
    logic        corrupt_flag [RAM_DEPTH];
    ram_word_t   corrupt_word [RAM_DEPTH];
    logic [31:0] lfsr_state = LFSR_SEED;
    int          value_errors = 0;
    int          frame_errors = 0;
    int          pass_frames = 0;
    int          pulse_count = 0;

    bram_check_top dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .tx         (tx),
        .pass_pulse (pass_pulse)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(negedge clk) begin
        if (rst_n && pass_pulse) begin
            pulse_count++;
        end
    end

    // Address in bits 9:0 and again from bit 16 up
    function automatic ram_word_t expected_word(ram_addr_t a);
        ram_word_t w;
        w = ram_word_t'(a) | (ram_word_t'(a) << PATTERN_SHIFT);
        return w;
    endfunction

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic logic [35:0] random_bits(int n);
        logic [35:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[34:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    task automatic check_field(input string name, input string field,
                               input logic [39:0] exp_val, input logic [39:0] act_val);
        assert (act_val === exp_val) else begin
            $display("FAILED %s: %s expected %h actual %h", name, field, exp_val, act_val);
            value_errors++;
        end
    endtask

    task automatic write_word(input ram_addr_t a, input ram_word_t w);
        @(posedge clk);
        #2;
        wr_en   = 1'b1;
        wr_addr = a;
        wr_data = w;
        @(posedge clk);
        #2;
        wr_en = 1'b0;
    endtask

    // Bit 35 is always zero in the pattern, so this word always mismatches
    task automatic corrupt(input ram_addr_t a);
        ram_word_t w;
        w = ram_word_t'(random_bits(DATA_W)) | {1'b1, {(DATA_W - 1){1'b0}}};
        write_word(a, w);
        corrupt_flag[a] = 1'b1;
        corrupt_word[a] = w;
    endtask

    task automatic repair(input ram_addr_t a);
        write_word(a, expected_word(a));
        corrupt_flag[a] = 1'b0;
    endtask

    task automatic next_frame(input string name, output frame_rec_t f, output logic got);
        int waited;
        waited = 0;
        f = '0;
        got = 1'b0;
        while (frames.size() == 0 && waited < FRAME_WAIT) begin
            @(posedge clk);
            waited++;
        end
        if (frames.size() == 0) begin
            $display("%s: no frame arrived within %0d cycles", name, FRAME_WAIT);
            frame_errors++;
        end else begin
            f = frames.pop_front();
            got = 1'b1;
        end
    endtask

    // One error frame per corrupted word in address order, then the pass frame
    task automatic check_pass(input string name);
        frame_rec_t f;
        logic       got;
        int         n;
        n = 0;
        for (int i = 0; i < RAM_DEPTH; i++) begin
            if (corrupt_flag[i]) begin
                next_frame(name, f, got);
                if (got) begin
                    check_field(name, "frame tag", 40'(TAG_ERROR), 40'(f.tag));
                    check_field(name, "address", 40'(i), 40'(f.addr));
                    check_field(name, "expected word",
                                40'(expected_word(ram_addr_t'(i))), f.expected);
                    check_field(name, "actual word", 40'(corrupt_word[i]), f.actual);
                end
                n++;
            end
        end
        next_frame(name, f, got);
        if (got) begin
            check_field(name, "frame tag", 40'(TAG_PASS), 40'(f.tag));
            check_field(name, "error count", 40'(n), 40'(f.count));
            pass_frames++;
        end
    endtask

    // Samples at mid-bit on falling clock edges
    task automatic receive_byte(output byte_t b);
        b = '0;
        @(negedge clk);
        while (tx !== 1'b0) begin
            @(negedge clk);
        end
        repeat (BAUD_DIV / 2) @(negedge clk);
        assert (tx === 1'b0) else begin
            $display("Serial decoder: start bit did not last half a bit time");
            frame_errors++;
        end
        for (int i = 0; i < 8; i++) begin
            repeat (BAUD_DIV) @(negedge clk);
            b[i] = tx;
        end
        repeat (BAUD_DIV) @(negedge clk);
        assert (tx === 1'b1) else begin
            $display("Serial decoder: stop bit was low");
            frame_errors++;
        end
    endtask

    task automatic print_summary();
        $display("Errors: %0d value mismatches, %0d missing or malformed frames",
                 value_errors, frame_errors);
    endtask

    initial begin : serial_decoder
        byte_t       tag;
        byte_t       b;
        logic [95:0] body;
        frame_rec_t  f;
        wait (rst_n === 1'b1);
        forever begin
            receive_byte(tag);
            f = '0;
            f.tag = tag;
            if (tag == TAG_ERROR) begin
                body = '0;
                for (int i = 0; i < ERR_FRAME_LEN - 1; i++) begin
                    receive_byte(b);
                    body = {body[87:0], b};
                end
                f.addr     = body[95:80];
                f.expected = body[79:40];
                f.actual   = body[39:0];
                frames.push_back(f);
            end else if (tag == TAG_PASS) begin
                receive_byte(b);
                f.count[15:8] = b;
                receive_byte(b);
                f.count[7:0] = b;
                frames.push_back(f);
            end else begin
                $display("Serial decoder: unknown frame tag %h", tag);
                frame_errors++;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles with passes still unchecked",
                 WATCHDOG_CYCLES);
        print_summary();
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin : main_sequence
        ram_addr_t a;
        rst_n   = 1'b0;
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        for (int i = 0; i < RAM_DEPTH; i++) begin
            corrupt_flag[i] = 1'b0;
            corrupt_word[i] = '0;
        end
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        check_pass("clean_memory");

        // Writes land right after a pass frame, scan is near address 0
        a = ram_addr_t'(random_bits(9)) + 10'd16;
        corrupt(a);
        check_pass("single_corruption");

        repair(a);
        a = ram_addr_t'(random_bits(9)) + 10'd16;
        corrupt(a);
        corrupt(a + 1'b1);
        check_pass("adjacent_corruptions");

        repair(a);
        repair(a + 1'b1);
        corrupt(ram_addr_t'(LAST_ADDR));
        check_pass("last_address");

        repair(ram_addr_t'(LAST_ADDR));
        check_pass("repair");
        check_field("repair", "pass_pulse count", 40'(pass_frames), 40'(pulse_count));

        if (frames.size() != 0) begin
            $display("Extra frames arrived after the last pass: %0d", frames.size());
            frame_errors++;
        end
        print_summary();
        if (value_errors == 0 && frame_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: bram_check.f
verilog/mem_check_pkg.sv
verilog/report_pkg.sv
verilog/scan_sequencer.sv
verilog/pattern_ram.sv
verilog/read_compare.sv
verilog/error_reporter.sv
verilog/uart_tx.sv
verilog/bram_check_top.sv
verif/bram_check_sva.sv
verif/bram_check_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module bram_check_tb -f bram_check.f \
    --Mdir obj_dir -o bram_check_sim

./obj_dir/bram_check_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST RESULT: PASS$" sim.log; then
    exit 0
fi
exit 1
